// ==== common/building_pkg.sv ====
////////////////////////////////////////
// Building geometry: floor count and
// the floor number and floor mask types
////////////////////////////////////////

package building_pkg;

    // Floors served by the car, lowest floor is 0
    localparam int num_floors = 11;

    // Width of a floor number
    localparam int floor_width = 4;

    ////////////////////////////////////////
    // Types
    ////////////////////////////////////////

    // Floor number, 0 up to num_floors - 1
    typedef logic [floor_width-1:0] floor_t;

    // One bit per floor, bit 0 is the lowest floor
    typedef logic [num_floors-1:0] floor_mask_t;

endpackage

// ==== common/dispatch_pkg.sv ====
////////////////////////////////////////
// Dispatch types: travel direction
////////////////////////////////////////

package dispatch_pkg;

    // Direction the car sweeps through its requests
    typedef enum logic {
        dir_down = 1'b0,
        dir_up   = 1'b1
    } travel_dir_e;

endpackage

// ==== common/car_status_if.sv ====
////////////////////////////////////////
// Car status bundle: floor, motion,
// power and emergency
////////////////////////////////////////

interface car_status_if;
    import building_pkg::*;

    // Floor the car is at or last passed
    floor_t current_floor;

    // High while the car travels between floors
    logic moving;

    // Main power switch and emergency stop
    logic power_on;
    logic emergency;

    // Receivers only read the status
    modport sink (
        input current_floor,
        input moving,
        input power_on,
        input emergency
    );

endinterface

// ==== src/request_register.sv ====
////////////////////////////////////////
// Request register: hall call and car
// panel lights, and the pending mask
////////////////////////////////////////

module request_register (
    input  logic                  clock,
    input  logic                  reset_n,
    input  building_pkg::floor_mask_t floor_call_buttons,
    input  building_pkg::floor_mask_t panel_buttons,
    car_status_if.sink            car,
    output building_pkg::floor_mask_t call_button_lights,
    output building_pkg::floor_mask_t panel_button_lights,
    output building_pkg::floor_mask_t pending
);
    import building_pkg::*;

    floor_mask_t here_mask;
    logic        latch_enable;
    logic        clear_enable;

    ////////////////////////////////////////
    // Masks shared by both light sets
    ////////////////////////////////////////

    // One-hot of the current floor, all zero for an out of range floor
    always_comb begin
        here_mask = '0;
        for (int i = 0; i < num_floors; i++) begin
            if (car.current_floor == floor_t'(i)) begin
                here_mask[i] = 1'b1;
            end
        end
    end

    // New presses only latch with power on and no emergency
    assign latch_enable = car.power_on && !car.emergency;

    // A stopped car serves its floor, emergency or not
    assign clear_enable = car.power_on && !car.moving;

    // Set by presses away from the current floor, then drop the served floor
    function automatic floor_mask_t next_lights(
        input floor_mask_t lights,
        input floor_mask_t buttons
    );
        floor_mask_t set_mask;
        floor_mask_t clear_mask;
        set_mask   = latch_enable ? (buttons & ~here_mask) : '0;
        clear_mask = clear_enable ? here_mask : '0;
        return (lights | set_mask) & ~clear_mask;
    endfunction

    ////////////////////////////////////////
    // Light registers
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            call_button_lights  <= '0;
            panel_button_lights <= '0;
        end else begin
            call_button_lights  <= next_lights(call_button_lights, floor_call_buttons);
            panel_button_lights <= next_lights(panel_button_lights, panel_buttons);
        end
    end

    // A floor is pending if either of its buttons is lit
    assign pending = call_button_lights | panel_button_lights;

endmodule

// ==== dispatch/travel_direction.sv ====
////////////////////////////////////////
// Travel direction register, flips when
// no request is left ahead of the car
////////////////////////////////////////

module travel_direction (
    input  logic                      clock,
    input  logic                      reset_n,
    car_status_if.sink                car,
    input  building_pkg::floor_mask_t pending,
    output dispatch_pkg::travel_dir_e travel_dir
);
    import building_pkg::*;
    import dispatch_pkg::*;

    logic any_above;
    logic any_below;

    ////////////////////////////////////////
    // Request position relative to the car
    ////////////////////////////////////////

    always_comb begin
        any_above = 1'b0;
        any_below = 1'b0;
        for (int i = 0; i < num_floors; i++) begin
            if (pending[i] && (floor_t'(i) > car.current_floor)) begin
                any_above = 1'b1;
            end
            if (pending[i] && (floor_t'(i) < car.current_floor)) begin
                any_below = 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Direction FSM
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            travel_dir <= dir_up;
        end else begin
            case (travel_dir)
                dir_up: begin
                    // Nothing left above, turn round for the floors below
                    if (!any_above && any_below) begin
                        travel_dir <= dir_down;
                    end
                end
                dir_down: begin
                    if (!any_below && any_above) begin
                        travel_dir <= dir_up;
                    end
                end
                default: travel_dir <= dir_up;
            endcase
        end
    end

endmodule

// ==== dispatch/target_select.sv ====
////////////////////////////////////////
// Target floor register and the
// activate request to the car
////////////////////////////////////////

module target_select (
    input  logic                      clock,
    input  logic                      reset_n,
    car_status_if.sink                car,
    input  building_pkg::floor_mask_t pending,
    input  dispatch_pkg::travel_dir_e travel_dir,
    output building_pkg::floor_t      target_floor,
    output logic                      activate_elevator
);
    import building_pkg::*;
    import dispatch_pkg::*;

    floor_t next_target;
    logic   next_activate;

    ////////////////////////////////////////
    // Nearest request ahead of the car
    ////////////////////////////////////////

    // Falls back to the current floor when nothing lies ahead
    function automatic floor_t nearest_ahead(
        input floor_mask_t req,
        input floor_t      here,
        input travel_dir_e dir
    );
        floor_t pick;
        pick = here;
        if (dir == dir_up) begin
            // Scan downward so the lowest floor above wins
            for (int i = num_floors - 1; i >= 0; i--) begin
                if (req[i] && (floor_t'(i) > here)) begin
                    pick = floor_t'(i);
                end
            end
        end else begin
            // Scan upward so the highest floor below wins
            for (int i = 0; i < num_floors; i++) begin
                if (req[i] && (floor_t'(i) < here)) begin
                    pick = floor_t'(i);
                end
            end
        end
        return pick;
    endfunction

    // Target is frozen while the car travels
    assign next_target = car.moving ? target_floor
                                    : nearest_ahead(pending, car.current_floor, travel_dir);

    assign next_activate = (next_target != car.current_floor) && !car.moving
                           && car.power_on && !car.emergency;

    ////////////////////////////////////////
    // Output registers
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            target_floor      <= '0;
            activate_elevator <= 1'b0;
        end else begin
            target_floor      <= next_target;
            activate_elevator <= next_activate;
        end
    end

endmodule

// ==== src/floor_logic_top.sv ====
////////////////////////////////////////
// Floor logic top: request register,
// direction and target select
////////////////////////////////////////

module floor_logic_top (
    input  logic                      clock,
    input  logic                      reset_n,
    input  building_pkg::floor_mask_t floor_call_buttons,
    input  building_pkg::floor_mask_t panel_buttons,
    input  logic                      emergency_btn,
    input  logic                      power_switch,
    input  building_pkg::floor_t      current_floor,
    input  logic                      car_moving,
    output building_pkg::floor_mask_t call_button_lights,
    output building_pkg::floor_mask_t panel_button_lights,
    output building_pkg::floor_t      target_floor,
    output logic                      activate_elevator,
    output logic                      travel_up
);
    import building_pkg::*;
    import dispatch_pkg::*;

    floor_mask_t pending;
    travel_dir_e travel_dir;

    ////////////////////////////////////////
    // Car status bundle
    ////////////////////////////////////////

    car_status_if car ();

    assign car.current_floor = current_floor;
    assign car.moving        = car_moving;
    assign car.power_on      = power_switch;
    assign car.emergency     = emergency_btn;

    ////////////////////////////////////////
    // Blocks
    ////////////////////////////////////////

    request_register u_request_register (
        .clock               (clock),
        .reset_n             (reset_n),
        .floor_call_buttons  (floor_call_buttons),
        .panel_buttons       (panel_buttons),
        .car                 (car),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights),
        .pending             (pending)
    );

    travel_direction u_travel_direction (
        .clock      (clock),
        .reset_n    (reset_n),
        .car        (car),
        .pending    (pending),
        .travel_dir (travel_dir)
    );

    target_select u_target_select (
        .clock             (clock),
        .reset_n           (reset_n),
        .car               (car),
        .pending           (pending),
        .travel_dir        (travel_dir),
        .target_floor      (target_floor),
        .activate_elevator (activate_elevator)
    );

    assign travel_up = (travel_dir == dir_up);

endmodule

// ==== dv/clock_gen.sv ====
////////////////////////////////////////
// Testbench clock and reset generator
////////////////////////////////////////

module clock_gen #(
    parameter int period       = 100,
    parameter int reset_cycles = 4
) (
    output logic clock,
    output logic reset_n
);

    initial begin
        clock = 1'b0;
        forever #(period / 2) clock = ~clock;
    end

    // Release lands on a falling edge, after reset_cycles rising edges
    initial begin
        reset_n = 1'b0;
        #(period * reset_cycles) reset_n = 1'b1;
    end

endmodule

// ==== dv/floor_logic_tb.sv ====
////////////////////////////////////////
// Floor logic testbench: steps from the
// stim file, output checks and report
////////////////////////////////////////

module floor_logic_tb;
    import building_pkg::*;

    localparam int step_cycles  = 4;
    localparam int reset_cycles = 4;
    localparam int slack_cycles = 20;

    logic        clock;
    logic        reset_n;
    floor_mask_t floor_call_buttons;
    floor_mask_t panel_buttons;
    logic        emergency_btn;
    logic        power_switch;
    floor_t      current_floor;
    logic        car_moving;
    floor_mask_t call_button_lights;
    floor_mask_t panel_button_lights;
    floor_t      target_floor;
    logic        activate_elevator;
    logic        travel_up;

    // One entry per step of the stim file
    string       step_name[$];
    floor_mask_t call_in[$];
    floor_mask_t panel_in[$];
    floor_t      floor_in[$];
    logic        moving_in[$];
    logic        power_in[$];
    logic        emergency_in[$];
    floor_mask_t call_exp[$];
    floor_mask_t panel_exp[$];
    floor_t      target_exp[$];
    logic        activate_exp[$];
    logic        up_exp[$];

    int cycle_count = 0;
    int cycle_limit = 0;
    int pass_count  = 0;
    int fail_count  = 0;

    clock_gen #(.period(100), .reset_cycles(reset_cycles)) u_clock_gen (
        .clock   (clock),
        .reset_n (reset_n)
    );

    floor_logic_top UUT (
        .clock               (clock),
        .reset_n             (reset_n),
        .floor_call_buttons  (floor_call_buttons),
        .panel_buttons       (panel_buttons),
        .emergency_btn       (emergency_btn),
        .power_switch        (power_switch),
        .current_floor       (current_floor),
        .car_moving          (car_moving),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights),
        .target_floor        (target_floor),
        .activate_elevator   (activate_elevator),
        .travel_up           (travel_up)
    );

    ////////////////////////////////////////
    // Stim file and step tasks
    ////////////////////////////////////////

    task automatic load_steps(output bit opened);
        int          fd;
        int          fields;
        string       line;
        string       name;
        floor_mask_t c_in;
        floor_mask_t p_in;
        floor_t      f_in;
        logic        m_in;
        logic        pw_in;
        logic        e_in;
        floor_mask_t c_exp;
        floor_mask_t p_exp;
        floor_t      t_exp;
        logic        a_exp;
        logic        u_exp;
        opened = 1'b0;
        fd = $fopen("dv/floor_logic_stim.txt", "r");
        if (fd != 0) begin
            opened = 1'b1;
            while (!$feof(fd)) begin
                line = "";
                // Lines opening with # are column notes
                if ($fgets(line, fd) != 0 && line.len() > 0 && line.getc(0) != 8'h23) begin
                    fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h",
                                     name, c_in, p_in, f_in, m_in, pw_in, e_in,
                                     c_exp, p_exp, t_exp, a_exp, u_exp);
                    if (fields == 12) begin
                        step_name.push_back(name);
                        call_in.push_back(c_in);
                        panel_in.push_back(p_in);
                        floor_in.push_back(f_in);
                        moving_in.push_back(m_in);
                        power_in.push_back(pw_in);
                        emergency_in.push_back(e_in);
                        call_exp.push_back(c_exp);
                        panel_exp.push_back(p_exp);
                        target_exp.push_back(t_exp);
                        activate_exp.push_back(a_exp);
                        up_exp.push_back(u_exp);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_step(input int idx);
        floor_call_buttons = call_in[idx];
        panel_buttons      = panel_in[idx];
        current_floor      = floor_in[idx];
        car_moving         = moving_in[idx];
        power_switch       = power_in[idx];
        emergency_btn      = emergency_in[idx];
    endtask

    task automatic check_step(input int idx, output int errors);
        errors = 0;
        if (call_button_lights !== call_exp[idx]) begin
            $display("mismatch at %0t: call_button_lights expected %h actual %h",
                     $time, call_exp[idx], call_button_lights);
            errors++;
        end
        if (panel_button_lights !== panel_exp[idx]) begin
            $display("mismatch at %0t: panel_button_lights expected %h actual %h",
                     $time, panel_exp[idx], panel_button_lights);
            errors++;
        end
        if (target_floor !== target_exp[idx]) begin
            $display("mismatch at %0t: target_floor expected %h actual %h",
                     $time, target_exp[idx], target_floor);
            errors++;
        end
        if (activate_elevator !== activate_exp[idx]) begin
            $display("mismatch at %0t: activate_elevator expected %h actual %h",
                     $time, activate_exp[idx], activate_elevator);
            errors++;
        end
        if (travel_up !== up_exp[idx]) begin
            $display("mismatch at %0t: travel_up expected %h actual %h",
                     $time, up_exp[idx], travel_up);
            errors++;
        end
    endtask

    ////////////////////////////////////////
    // Watchdog and main sequence
    ////////////////////////////////////////

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("run timed out after %0d cycles before all steps finished", cycle_count);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        bit opened;
        int errors;
        floor_call_buttons = '0;
        panel_buttons      = '0;
        emergency_btn      = 1'b0;
        power_switch       = 1'b0;
        current_floor      = '0;
        car_moving         = 1'b0;
        load_steps(opened);
        if (!opened || step_name.size() == 0) begin
            $display("could not read any step from dv/floor_logic_stim.txt");
            $display("*** FAILED ***");
            $finish;
        end else begin
            cycle_limit = reset_cycles + step_cycles * step_name.size() + slack_cycles;
            // Reset releases on a falling edge, so the first step drives there
            @(posedge reset_n);
            for (int i = 0; i < step_name.size(); i++) begin
                drive_step(i);
                repeat (step_cycles) @(posedge clock);
                @(negedge clock);
                check_step(i, errors);
                if (errors == 0) begin
                    pass_count++;
                    $display("step %0d %s: pass", i, step_name[i]);
                end else begin
                    fail_count++;
                    $display("step %0d %s: fail with %0d wrong outputs", i, step_name[i], errors);
                end
            end
            $display("steps passed: %0d, steps failed: %0d", pass_count, fail_count);
            if (fail_count == 0) begin
                $display("*** PASSED ***");
            end else begin
                $display("*** FAILED ***");
            end
            $finish;
        end
    end

endmodule

// ==== dv/floor_logic_stim.txt ====
# name | in: call panel floor moving power emergency | exp: call panel target activate up
# Masks are 11 bit hex with bit 0 the lowest floor, every field is hex
# Idle car after reset
reset_state      000 000 0 0 1 0   000 000 0 0 1
# Car at floor 0, call 5 and panel 3, press of floor 0 stays dark
press_from_0     021 008 0 0 1 0   020 008 3 1 1
# Target frozen while moving, then floor 3 served
moving_past_1    000 000 1 1 1 0   020 008 3 0 1
stop_at_3        000 000 3 0 1 0   020 000 5 1 1
# Floor 5 served with only floor 1 left, direction turns down
stop_at_5        000 002 5 0 1 0   000 002 1 1 0
# Emergency and power off block new presses and activation
emergency_press  100 200 5 0 1 1   000 002 1 0 0
power_off_press  080 000 5 0 0 0   000 002 1 0 0
power_restored   000 000 5 0 1 0   000 002 1 1 0
# Car travels down and floor 1 clears during an emergency stop
moving_past_3    000 000 3 1 1 0   000 002 1 0 0
emergency_at_1   000 000 1 0 1 1   000 000 1 0 0
# New call above turns the direction back up
call_above_1     010 000 1 0 1 0   010 000 4 1 1

// ==== floor_logic_top.f ====
common/building_pkg.sv
common/dispatch_pkg.sv
common/car_status_if.sv
src/request_register.sv
dispatch/travel_direction.sv
dispatch/target_select.sv
src/floor_logic_top.sv
dv/clock_gen.sv
dv/floor_logic_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the floor logic testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

log_file=sim.log

verilator --binary --timing \
    --top-module floor_logic_tb \
    --Mdir obj_dir \
    -o floor_logic_sim \
    -f floor_logic_top.f

./obj_dir/floor_logic_sim | tee "$log_file"

if grep -qF "*** PASSED ***" "$log_file"; then
    echo "simulation passed"
else
    echo "simulation failed, see $log_file"
    exit 1
fi
